//--- src/uart_trig_pkg.sv
package uart_trig_pkg;

	////////////////////////////////////////////////////////////
	// receiver sizing
	////////////////////////////////////////////////////////////
	localparam int baud_w = 16;
	localparam logic [baud_w-1:0] baud_reset = 16'd868;	// 115200 baud at 100 MHz

	localparam int frame_bits = 10;	// start + 8 data + stop
	localparam int bit_cnt_w = 4;
	localparam logic [bit_cnt_w-1:0] frame_last = bit_cnt_w'(frame_bits - 1);

	localparam int data_w = 8;

	////////////////////////////////////////////////////////////
	// AXI4-Lite
	////////////////////////////////////////////////////////////
	localparam int axi_addr_w = 4;
	localparam int axi_data_w = 32;
	localparam int axi_strb_w = axi_data_w / 8;
	localparam logic [1:0] axi_resp_okay = 2'b00;

	// register map, byte offsets
	typedef enum logic [axi_addr_w-1:0] {
		reg_ctrl  = 4'h0,
		reg_baud  = 4'h4,
		reg_match = 4'h8,
		reg_data  = 4'hC
	} reg_addr_t;

	// field positions
	localparam int arm_bit       = 0;	// reg_ctrl
	localparam int mask_lsb      = 8;	// reg_match
	localparam int mask_msb      = 15;
	localparam int rdy_bit       = 8;	// reg_data
	localparam int trig_seen_bit = 9;
	localparam int frame_err_bit = 10;

	////////////////////////////////////////////////////////////
	// receive FSM
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		rx_idle,
		rx_wait,
		rx_shift
	} rx_state_t;

endpackage

//--- src/uart_rx_ctrl_if.sv
`timescale 1ns/1ps

interface uart_rx_ctrl_if;

	// fsm -> datapath
	logic start;	// clear bit and baud counters
	logic receiving;	// baud counter enable
	logic set_rdy;	// good stop bit, publish byte
	logic clr_busy;

	// datapath -> fsm
	logic busy;
	logic shift;
	logic [uart_trig_pkg::bit_cnt_w-1:0] bit_cnt;
	logic stop_bit;

	modport fsm (
		output start, receiving, set_rdy, clr_busy,
		input  busy, shift, bit_cnt, stop_bit
	);

	modport dp (
		input  start, receiving, set_rdy, clr_busy,
		output busy, shift, bit_cnt, stop_bit
	);

endinterface

//--- src/uart_rx_fsm.sv
`timescale 1ns/1ps

module uart_rx_fsm (
	input  logic        clk,
	input  logic        rst_n,
	uart_rx_ctrl_if.fsm ctl
);

	uart_trig_pkg::rx_state_t state;
	uart_trig_pkg::rx_state_t nxt_state;
	logic last_bit;

	// tenth sample of the frame is being taken
	assign last_bit = ctl.shift && (ctl.bit_cnt == uart_trig_pkg::frame_last);

	////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= uart_trig_pkg::rx_idle;
		end else begin
			state <= nxt_state;
		end
	end

	////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////
	always_comb begin
		nxt_state     = state;
		ctl.start     = 1'b0;
		ctl.receiving = 1'b0;
		ctl.set_rdy   = 1'b0;
		ctl.clr_busy  = 1'b0;

		case (state)
			uart_trig_pkg::rx_idle: begin
				if (ctl.busy) begin	// start edge seen
					ctl.start = 1'b1;
					nxt_state = uart_trig_pkg::rx_wait;
				end
			end

			uart_trig_pkg::rx_wait: begin
				ctl.receiving = 1'b1;
				if (last_bit) begin
					nxt_state = uart_trig_pkg::rx_shift;
				end
			end

			uart_trig_pkg::rx_shift: begin
				// one cycle to judge the stop bit
				ctl.clr_busy = 1'b1;
				ctl.set_rdy  = ctl.stop_bit;	// low stop bit drops the byte
				nxt_state    = uart_trig_pkg::rx_idle;
			end

			default: begin
				nxt_state = uart_trig_pkg::rx_idle;
			end
		endcase
	end

endmodule

//--- src/uart_rx_datapath.sv
`timescale 1ns/1ps

module uart_rx_datapath (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               rx,
	input  logic [uart_trig_pkg::baud_w-1:0]   baud_div,
	input  logic                               clr_rdy,
	uart_rx_ctrl_if.dp                         ctl,
	output logic [uart_trig_pkg::data_w-1:0]   rx_data,
	output logic                               rdy,
	output logic                               frame_err
);

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic rx_fall;

	logic [uart_trig_pkg::baud_w-1:0] baud_cnt;
	logic [uart_trig_pkg::baud_w-1:0] half_cnt;
	logic [uart_trig_pkg::baud_w-1:0] full_cnt;

	logic [uart_trig_pkg::frame_bits-1:0] shift_reg;

	////////////////////////////////////////////////////////////
	// line synchronizer and start detect
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;	// line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign rx_fall = rx_prev & ~rx_sync;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctl.busy <= 1'b0;
		end else if (rx_fall) begin	// an edge in the release cycle starts the next frame
			ctl.busy <= 1'b1;
		end else if (ctl.clr_busy) begin
			ctl.busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// baud and bit counters
	////////////////////////////////////////////////////////////
	assign half_cnt = baud_div >> 1;
	assign full_cnt = baud_div - 1'b1;

	// first sample mid start bit, then one per bit period
	assign ctl.shift = ctl.receiving &&
		((ctl.bit_cnt == '0) ? (baud_cnt == half_cnt) : (baud_cnt == full_cnt));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			baud_cnt    <= '0;
			ctl.bit_cnt <= '0;
		end else begin
			if (ctl.start || ctl.shift)
				baud_cnt <= '0;
			else if (ctl.receiving)
				baud_cnt <= baud_cnt + 1'b1;

			if (ctl.start)
				ctl.bit_cnt <= '0;
			else if (ctl.shift)
				ctl.bit_cnt <= ctl.bit_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// shift register, output byte and flags
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (ctl.shift)
			shift_reg <= {rx_sync, shift_reg[uart_trig_pkg::frame_bits-1:1]};	// LSB first
	end

	assign ctl.stop_bit = shift_reg[uart_trig_pkg::frame_bits-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_data   <= '0;
			rdy       <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			if (ctl.set_rdy)
				rx_data <= shift_reg[uart_trig_pkg::data_w:1];	// drop start and stop

			if (ctl.set_rdy)
				rdy <= 1'b1;	// set wins over a read in the same cycle
			else if (clr_rdy)
				rdy <= 1'b0;

			frame_err <= ctl.clr_busy & ~ctl.set_rdy;	// single-cycle pulse
		end
	end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             rx,
	input  logic [uart_trig_pkg::baud_w-1:0] baud_div,
	input  logic [uart_trig_pkg::data_w-1:0] match,
	input  logic [uart_trig_pkg::data_w-1:0] mask,
	input  logic                             armed,
	input  logic                             clr_rdy,
	output logic [uart_trig_pkg::data_w-1:0] rx_data,
	output logic                             rdy,
	output logic                             trig,
	output logic                             frame_err
);

	uart_rx_ctrl_if ctl ();

	logic byte_new;	// rx_data just reloaded
	logic hit;

	uart_rx_fsm u_fsm (
		.clk   (clk),
		.rst_n (rst_n),
		.ctl   (ctl.fsm)
	);

	uart_rx_datapath u_dp (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.baud_div  (baud_div),
		.clr_rdy   (clr_rdy),
		.ctl       (ctl.dp),
		.rx_data   (rx_data),
		.rdy       (rdy),
		.frame_err (frame_err)
	);

	// mask bit set means don't care
	assign hit = ((rx_data ^ match) & ~mask) == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_new <= 1'b0;
			trig     <= 1'b0;
		end else begin
			byte_new <= ctl.set_rdy;	// fires for every frame, even if rdy was already high
			trig     <= byte_new & armed & hit;
		end
	end

endmodule

//--- src/trig_cfg_regs.sv
`timescale 1ns/1ps

module trig_cfg_regs (
	input  logic                                 clk,
	input  logic                                 rst_n,
	// AXI4-Lite slave
	input  logic [uart_trig_pkg::axi_addr_w-1:0] awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [uart_trig_pkg::axi_data_w-1:0] wdata,
	input  logic [uart_trig_pkg::axi_strb_w-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [uart_trig_pkg::axi_addr_w-1:0] araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [uart_trig_pkg::axi_data_w-1:0] rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	// receiver side
	output logic [uart_trig_pkg::baud_w-1:0]     baud_div,
	output logic [uart_trig_pkg::data_w-1:0]     match,
	output logic [uart_trig_pkg::data_w-1:0]     mask,
	output logic                                 armed,
	output logic                                 clr_rdy,
	input  logic [uart_trig_pkg::data_w-1:0]     rx_data,
	input  logic                                 rdy,
	input  logic                                 trig,
	input  logic                                 frame_err
);

	uart_trig_pkg::reg_addr_t wr_addr;
	uart_trig_pkg::reg_addr_t rd_addr;

	logic wr_accept;
	logic rd_accept;
	logic clr_trig_seen;
	logic clr_frame_err;
	logic trig_seen;
	logic frame_err_seen;
	logic [uart_trig_pkg::axi_data_w-1:0] rd_word;

	assign wr_addr = uart_trig_pkg::reg_addr_t'(awaddr);
	assign rd_addr = uart_trig_pkg::reg_addr_t'(araddr);

	////////////////////////////////////////////////////////////
	// handshakes
	////////////////////////////////////////////////////////////
	assign wr_accept = awvalid & wvalid & ~bvalid;	// one outstanding response at a time
	assign rd_accept = arvalid & ~rvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;
	assign arready   = rd_accept;
	assign bresp     = uart_trig_pkg::axi_resp_okay;
	assign rresp     = uart_trig_pkg::axi_resp_okay;

	assign clr_rdy = rd_accept && (rd_addr == uart_trig_pkg::reg_data);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_accept)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (rd_accept)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// configuration and sticky status
	////////////////////////////////////////////////////////////
	// write-one-to-clear on reg_data
	assign clr_trig_seen = wr_accept && (wr_addr == uart_trig_pkg::reg_data) && wstrb[1] &&
		wdata[uart_trig_pkg::trig_seen_bit];
	assign clr_frame_err = wr_accept && (wr_addr == uart_trig_pkg::reg_data) && wstrb[1] &&
		wdata[uart_trig_pkg::frame_err_bit];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed          <= 1'b0;
			baud_div       <= uart_trig_pkg::baud_reset;
			match          <= '0;
			mask           <= '0;
			trig_seen      <= 1'b0;
			frame_err_seen <= 1'b0;
		end else begin
			if (wr_accept) begin
				case (wr_addr)
					uart_trig_pkg::reg_ctrl: begin
						if (wstrb[0]) armed <= wdata[uart_trig_pkg::arm_bit];
					end
					uart_trig_pkg::reg_baud: begin
						if (wstrb[0]) baud_div[7:0] <= wdata[7:0];
						if (wstrb[1]) baud_div[15:8] <= wdata[15:8];
					end
					uart_trig_pkg::reg_match: begin
						if (wstrb[0]) match <= wdata[uart_trig_pkg::data_w-1:0];
						if (wstrb[1]) mask <= wdata[uart_trig_pkg::mask_msb:uart_trig_pkg::mask_lsb];
					end
					default: ;	// unmapped
				endcase
			end

			if (trig)	// new event beats a clear
				trig_seen <= 1'b1;
			else if (clr_trig_seen)
				trig_seen <= 1'b0;

			if (frame_err)
				frame_err_seen <= 1'b1;
			else if (clr_frame_err)
				frame_err_seen <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////
	always_comb begin
		rd_word = '0;
		case (rd_addr)
			uart_trig_pkg::reg_ctrl:  rd_word[uart_trig_pkg::arm_bit] = armed;
			uart_trig_pkg::reg_baud:  rd_word[uart_trig_pkg::baud_w-1:0] = baud_div;
			uart_trig_pkg::reg_match: begin
				rd_word[uart_trig_pkg::data_w-1:0] = match;
				rd_word[uart_trig_pkg::mask_msb:uart_trig_pkg::mask_lsb] = mask;
			end
			uart_trig_pkg::reg_data: begin
				rd_word[uart_trig_pkg::data_w-1:0]     = rx_data;
				rd_word[uart_trig_pkg::rdy_bit]        = rdy;	// value before the clear
				rd_word[uart_trig_pkg::trig_seen_bit]  = trig_seen;
				rd_word[uart_trig_pkg::frame_err_bit]  = frame_err_seen;
			end
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_accept)
			rdata <= rd_word;	// held while rvalid waits on rready
	end

endmodule

//--- src/uart_trig_top.sv
`timescale 1ns/1ps

module uart_trig_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 rx,
	// AXI4-Lite slave
	input  logic [uart_trig_pkg::axi_addr_w-1:0] awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [uart_trig_pkg::axi_data_w-1:0] wdata,
	input  logic [uart_trig_pkg::axi_strb_w-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [uart_trig_pkg::axi_addr_w-1:0] araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [uart_trig_pkg::axi_data_w-1:0] rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	// to capture logic
	output logic                                 trig
);

	logic [uart_trig_pkg::baud_w-1:0] baud_div;
	logic [uart_trig_pkg::data_w-1:0] match;
	logic [uart_trig_pkg::data_w-1:0] mask;
	logic                             armed;
	logic                             clr_rdy;
	logic [uart_trig_pkg::data_w-1:0] rx_data;
	logic                             rdy;
	logic                             frame_err;

	trig_cfg_regs u_regs (
		.clk      (clk),      .rst_n    (rst_n),
		.awaddr   (awaddr),   .awvalid  (awvalid),  .awready (awready),
		.wdata    (wdata),    .wstrb    (wstrb),    .wvalid  (wvalid),  .wready (wready),
		.bresp    (bresp),    .bvalid   (bvalid),   .bready  (bready),
		.araddr   (araddr),   .arvalid  (arvalid),  .arready (arready),
		.rdata    (rdata),    .rresp    (rresp),    .rvalid  (rvalid),  .rready (rready),
		.baud_div (baud_div), .match    (match),    .mask    (mask),
		.armed    (armed),    .clr_rdy  (clr_rdy),
		.rx_data  (rx_data),  .rdy      (rdy),      .trig    (trig),    .frame_err (frame_err)
	);

	uart_rx u_rx (
		.clk      (clk),      .rst_n    (rst_n),    .rx      (rx),
		.baud_div (baud_div), .match    (match),    .mask    (mask),
		.armed    (armed),    .clr_rdy  (clr_rdy),
		.rx_data  (rx_data),  .rdy      (rdy),      .trig    (trig),    .frame_err (frame_err)
	);

endmodule

//--- testbench/uart_trig_assert.sv
`timescale 1ns/1ps

module uart_trig_assert (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic                                 trig,
	input logic                                 awready,
	input logic                                 bvalid,
	input logic                                 bready,
	input logic                                 rvalid,
	input logic                                 rready,
	input logic [uart_trig_pkg::axi_data_w-1:0] rdata
);

	////////////////////////////////////////////////////////////
	// trigger and AXI response rules
	////////////////////////////////////////////////////////////
	trig_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		trig |=> !trig)
		else $error("trig stayed high for more than one cycle");

	b_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	r_held: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

	// an accepted write blocks the next one behind its response
	aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		awready |=> bvalid && !awready)
		else $error("accepted write gave no pending response or a second accept");

endmodule

bind uart_trig_top uart_trig_assert u_assert (.*);

//--- testbench/uart_trig_tb.sv
`timescale 1ns/1ps

module uart_trig_tb;

	localparam int limit = 2000;	// cycles allowed for any one wait

	logic                                 clk = 1'b0;
	logic                                 rst_n;
	logic                                 rx;
	logic [uart_trig_pkg::axi_addr_w-1:0] awaddr;
	logic                                 awvalid;
	logic                                 awready;
	logic [uart_trig_pkg::axi_data_w-1:0] wdata;
	logic [uart_trig_pkg::axi_strb_w-1:0] wstrb;
	logic                                 wvalid;
	logic                                 wready;
	logic [1:0]                           bresp;
	logic                                 bvalid;
	logic                                 bready;
	logic [uart_trig_pkg::axi_addr_w-1:0] araddr;
	logic                                 arvalid;
	logic                                 arready;
	logic [uart_trig_pkg::axi_data_w-1:0] rdata;
	logic [1:0]                           rresp;
	logic                                 rvalid;
	logic                                 rready;
	logic                                 trig;

	int trig_cnt = 0;	// pulses seen on trig
	int exp_cnt = 0;

	uart_trig_top DUT (.*);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////
	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		abort_run();
	endtask

	// every bit not marked don't care must agree for a trigger
	function automatic logic expect_trig(input logic [7:0] b, input logic [7:0] m,
			input logic [7:0] dc, input logic arm);
		expect_trig = arm;
		for (int i = 0; i < 8; i++)
			if (!dc[i] && (b[i] != m[i]))
				expect_trig = 1'b0;
	endfunction

	always @(negedge clk) begin
		if (rst_n && trig) begin
			trig_cnt = trig_cnt + 1;
			assert (trig_cnt <= exp_cnt) else begin
				$display("FAILED at %0t ns: trig count expected %0d got %0d", $time, exp_cnt,
					trig_cnt);
				abort_run();
			end
		end
	end

	////////////////////////////////////////////////////////////
	// AXI4-Lite and serial drivers
	////////////////////////////////////////////////////////////
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] val,
			input logic [3:0] strb, input int hold);
		int n;
		@(posedge clk);
		#1;
		awaddr  = addr;
		wdata   = val;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!awready) begin
			n++;
			if (n > limit) timed_out("awready");
			@(negedge clk);
		end
		check_value("wready", 1, wready);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		@(negedge clk);
		while (!bvalid) begin
			n++;
			if (n > limit) timed_out("bvalid");
			@(negedge clk);
		end
		repeat (hold) @(negedge clk);	// bready held low meanwhile
		check_value("bvalid", 1, bvalid);
		check_value("bresp", 0, bresp);
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, input int hold, output logic [31:0] val);
		int n;
		logic [31:0] first;
		@(posedge clk);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready) begin
			n++;
			if (n > limit) timed_out("arready");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!rvalid) begin
			n++;
			if (n > limit) timed_out("rvalid");
			@(negedge clk);
		end
		first = rdata;
		repeat (hold) @(negedge clk);
		check_value("rvalid", 1, rvalid);
		check_value("rdata", first, rdata);
		check_value("rresp", 0, rresp);
		val = rdata;
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// reads reg_data until the given status bit is set
	task automatic poll_data(input int bit_idx, input int hold, output logic [31:0] val);
		int n;
		n = 0;
		axi_read(uart_trig_pkg::reg_data, hold, val);
		while (!val[bit_idx]) begin
			n++;
			if (n > limit / 4) timed_out("status bit in reg_data");
			axi_read(uart_trig_pkg::reg_data, hold, val);
		end
	endtask

	task automatic send_frame(input logic [7:0] val, input logic stop, input int period);
		logic [9:0] bits;
		bits = {stop, val, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			rx = bits[i];	// LSB first after the start bit
			repeat (period - 1) @(posedge clk);
		end
		@(posedge clk);
		#1;
		rx = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] word;
		logic [31:0] cfg;
		logic [31:0] rd;
		logic [7:0]  data;
		logic [7:0]  mask_val;
		logic [7:0]  match_val;
		logic        hit;
		int          period;
		void'($urandom(32'hcc51_6ca5));
		rst_n   = 1'b0;
		rx      = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// register reset values and read back
		axi_read(uart_trig_pkg::reg_ctrl, 0, word);
		check_value("reg_ctrl", 0, word);
		axi_read(uart_trig_pkg::reg_baud, 0, word);
		check_value("reg_baud", 868, word);
		axi_read(uart_trig_pkg::reg_match, 0, word);
		check_value("reg_match", 0, word);
		axi_read(uart_trig_pkg::reg_data, 0, word);
		check_value("reg_data", 0, word);
		axi_write(uart_trig_pkg::reg_ctrl, 32'h1, 4'hf, 0);
		axi_read(uart_trig_pkg::reg_ctrl, 0, word);
		check_value("reg_ctrl", 32'h1, word);
		axi_write(uart_trig_pkg::reg_baud, 32'h1234, 4'hf, 0);
		axi_write(uart_trig_pkg::reg_baud, 32'habcd, 4'h1, 0);	// low byte only
		axi_read(uart_trig_pkg::reg_baud, 0, word);
		check_value("reg_baud", 32'h12cd, word);
		axi_write(uart_trig_pkg::reg_match, 32'ha55a, 4'h3, 0);
		axi_write(uart_trig_pkg::reg_match, 32'h3c00, 4'h2, 0);
		axi_read(uart_trig_pkg::reg_match, 0, word);
		check_value("reg_match", 32'h3c5a, word);
		axi_write(4'h2, 32'hffff_ffff, 4'hf, 0);
		axi_read(4'h2, 0, word);
		check_value("unmapped 0x2", 0, word);
		axi_write(uart_trig_pkg::reg_ctrl, 32'h0, 4'hf, 0);

		// reception at two bit periods
		for (int p = 0; p < 2; p++) begin
			period = (p == 0) ? 16 : 23;
			axi_write(uart_trig_pkg::reg_baud, period, 4'hf, 0);
			repeat (20) begin
				data = $urandom;
				send_frame(data, 1'b1, period);
				poll_data(uart_trig_pkg::rdy_bit, 0, word);
				check_value("rx_data", data, word[7:0]);
				axi_read(uart_trig_pkg::reg_data, 0, word);
				check_value("rdy after read", 0, word[uart_trig_pkg::rdy_bit]);
			end
		end

		// armed trigger with random match and mask
		axi_write(uart_trig_pkg::reg_ctrl, 32'h1, 4'h1, 0);
		repeat (20) begin
			data      = $urandom;
			mask_val  = $urandom;
			match_val = ($urandom % 2) ? (data ^ (mask_val & 8'($urandom))) : 8'($urandom);
			hit       = expect_trig(data, match_val, mask_val, 1'b1);
			axi_write(uart_trig_pkg::reg_match, {16'h0, mask_val, match_val}, 4'h3, 0);
			exp_cnt += hit;
			send_frame(data, 1'b1, period);
			poll_data(uart_trig_pkg::rdy_bit, 0, word);
			check_value("trig pulses", exp_cnt, trig_cnt);
			check_value("trig_seen", hit, word[uart_trig_pkg::trig_seen_bit]);
			if (hit)
				axi_write(uart_trig_pkg::reg_data, 32'h200, 4'h2, 0);	// clear trig_seen
		end

		// disarmed, matching byte
		axi_write(uart_trig_pkg::reg_ctrl, 32'h0, 4'h1, 0);
		data = $urandom;
		axi_write(uart_trig_pkg::reg_match, {24'h0, data}, 4'h3, 0);
		exp_cnt += expect_trig(data, data, 8'h00, 1'b0);
		send_frame(data, 1'b1, period);
		poll_data(uart_trig_pkg::rdy_bit, 0, word);
		check_value("trig pulses", exp_cnt, trig_cnt);
		check_value("trig_seen", 0, word[uart_trig_pkg::trig_seen_bit]);

		// low stop bit while any byte would trigger, then a good frame
		axi_write(uart_trig_pkg::reg_match, 32'hff00, 4'h3, 0);
		axi_write(uart_trig_pkg::reg_ctrl, 32'h1, 4'h1, 0);
		send_frame(8'($urandom), 1'b0, period);
		poll_data(uart_trig_pkg::frame_err_bit, 0, word);
		check_value("rdy on bad frame", 0, word[uart_trig_pkg::rdy_bit]);
		check_value("trig pulses", exp_cnt, trig_cnt);
		axi_write(uart_trig_pkg::reg_data, 32'h400, 4'h2, 0);
		axi_read(uart_trig_pkg::reg_data, 0, word);
		check_value("frame_err", 0, word[uart_trig_pkg::frame_err_bit]);
		data = $urandom;
		exp_cnt += expect_trig(data, 8'h00, 8'hff, 1'b1);
		send_frame(data, 1'b1, period);
		poll_data(uart_trig_pkg::rdy_bit, 0, word);
		check_value("rx_data", data, word[7:0]);
		check_value("trig pulses", exp_cnt, trig_cnt);
		axi_write(uart_trig_pkg::reg_ctrl, 32'h0, 4'h1, 0);

		// stalled responses while a frame arrives
		data = $urandom;
		fork
			send_frame(data, 1'b1, period);
			begin
				repeat (4) begin
					cfg = $urandom;
					axi_write(uart_trig_pkg::reg_match, cfg, 4'h3, 1 + $urandom % 8);
					axi_read(uart_trig_pkg::reg_match, 1 + $urandom % 8, rd);
					check_value("reg_match", cfg & 32'hffff, rd);
				end
			end
		join
		poll_data(uart_trig_pkg::rdy_bit, 1 + $urandom % 8, word);
		check_value("rx_data", data, word[7:0]);
		check_value("trig pulses", exp_cnt, trig_cnt);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- uart_trig_top.f
src/uart_trig_pkg.sv
src/uart_rx_ctrl_if.sv
src/uart_rx_fsm.sv
src/uart_rx_datapath.sv
src/uart_rx.sv
src/trig_cfg_regs.sv
src/uart_trig_top.sv
testbench/uart_trig_assert.sv
testbench/uart_trig_tb.sv
